//--- Makefile
# Verilator build and run for the console glue logic

VERILATOR ?= verilator
TOP       ?= tb_glue
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- design/aspect_ratio.sv
`timescale 1ns/10ps
`default_nettype none

module aspect_ratio (
	input  wire                         clk_1x,
	input  wire                         RESET,
	input  wire                         system_pal,
	input  wire glue_pkg::crop_t        crop,
	input  wire                         blanks_off,
	input  wire                         direct_fb,
	input  wire glue_pkg::aspect_mode_t aspect_mode,
	output glue_pkg::ar_t               video_arx,
	output glue_pkg::ar_t               video_ary
);
	import glue_pkg::*;

	ar_t          core_x;
	ar_t          core_y;
	aspect_mode_t preset;

	//==========================================================================
	// Core ratio from standard and crop
	//==========================================================================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= AR_PLAIN_X;
			core_y <= AR_PLAIN_Y;
		end else if (blanks_off || direct_fb) begin
			core_x <= AR_PLAIN_X;
			core_y <= AR_PLAIN_Y;
		end else if (crop != 2'd3) begin
			if (system_pal) begin
				core_x <= AR_PAL_X[crop];
				core_y <= AR_PAL_Y[crop];
			end else begin
				core_x <= AR_NTSC_X[crop];
				core_y <= AR_NTSC_Y[crop];
			end
		end
	end

	// Scaler preset codes, denominator 0 selects them
	assign preset    = aspect_mode - 2'd1;
	assign video_arx = (aspect_mode == 2'd0) ? core_x : ar_t'(preset);
	assign video_ary = (aspect_mode == 2'd0) ? core_y : '0;

endmodule

`default_nettype wire

//--- design/glue_pkg.sv
`default_nettype none

package glue_pkg;

	//==========================================================================
	// Widths
	//==========================================================================

	typedef logic [26:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [31:0] word_t;
	typedef logic [9:0]  pifrom_addr_t;
	typedef logic [1:0]  pad_index_t;
	typedef logic [1:0]  crop_t;
	typedef logic [1:0]  aspect_mode_t;
	typedef logic [12:0] ar_t;
	typedef logic [5:0]  cfg_addr_t;

	// Video PLL reconfiguration sequence
	typedef enum logic [2:0] {
		CFG_IDLE,
		CFG_MODE,
		CFG_GAP1,
		CFG_FRAC,
		CFG_GAP2,
		CFG_START,
		CFG_GAP3
	} cfg_state_t;

	//==========================================================================
	// Download slots and memory map
	//==========================================================================

	// Matched against the low six bits of the slot index
	localparam logic [5:0] DL_PIFROM   = 6'd0;
	localparam logic [5:0] DL_CART_N64 = 6'd1;
	localparam logic [5:0] DL_CART_GB  = 6'd2;

	localparam ioctl_addr_t CARTGB_START = 27'd8388608;

	//==========================================================================
	// PLL manager and video constants
	//==========================================================================

	localparam cfg_addr_t CFG_REG_MODE  = 6'd0;
	localparam cfg_addr_t CFG_REG_FRAC  = 6'd7;
	localparam cfg_addr_t CFG_REG_START = 6'd2;

	localparam word_t FRAC_PAL  = 32'd4024384270;
	localparam word_t FRAC_NTSC = 32'd3274482981;

	// Indexed by vertical crop, crop 3 has no entry
	localparam ar_t AR_PAL_X [0:2]  = '{13'd512, 13'd1024, 13'd2048};
	localparam ar_t AR_PAL_Y [0:2]  = '{13'd387, 13'd731, 13'd1419};
	localparam ar_t AR_NTSC_X [0:2] = '{13'd512, 13'd1280, 13'd2560};
	localparam ar_t AR_NTSC_Y [0:2] = '{13'd381, 13'd889, 13'd1714};

	localparam ar_t AR_PLAIN_X = 13'd4;
	localparam ar_t AR_PLAIN_Y = 13'd3;

	// User port pin per controller port
	localparam logic [2:0] SNAC_PIN [0:3] = '{3'd1, 3'd0, 3'd5, 3'd4};

endpackage

`default_nettype wire

//--- design/glue_top.sv
`timescale 1ns/10ps
`default_nettype none

module glue_top (
	input  wire                         clk_1x,
	input  wire                         RESET,
	input  wire                         system_pal,
	// Host download
	input  wire                         ioctl_download,
	input  wire glue_pkg::dl_index_t    ioctl_index,
	input  wire glue_pkg::ioctl_addr_t  ioctl_addr,
	input  wire glue_pkg::ioctl_data_t  ioctl_dout,
	input  wire                         ioctl_wr,
	output wire                         ioctl_wait,
	output wire glue_pkg::pifrom_addr_t pifrom_wraddress,
	output wire glue_pkg::word_t        pifrom_wrdata,
	output wire                         pifrom_wren,
	output wire glue_pkg::ioctl_addr_t  ram_addr,
	output wire glue_pkg::word_t        ram_data,
	output wire                         ram_wr,
	input  wire                         ram_ready,
	output wire                         romcopy_start,
	output wire glue_pkg::ioctl_addr_t  romcopy_size,
	output wire                         cart_loaded,
	// PLL manager
	input  wire                         cfg_waitrequest,
	output wire                         cfg_write,
	output wire glue_pkg::cfg_addr_t    cfg_addr,
	output wire glue_pkg::word_t        cfg_data,
	// Scaler aspect
	input  wire glue_pkg::crop_t        crop,
	input  wire                         blanks_off,
	input  wire                         direct_fb,
	input  wire glue_pkg::aspect_mode_t aspect_mode,
	output wire glue_pkg::ar_t          video_arx,
	output wire glue_pkg::ar_t          video_ary,
	// User port
	input  wire                         snac_en,
	input  wire glue_pkg::pad_index_t   pad_index,
	input  wire                         snac_out,
	input  wire [6:0]                   user_in,
	output wire [6:0]                   user_out,
	output wire                         snac_in
);

	rom_download u_rom_download (
		.clk_1x, .RESET,
		.ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout, .ioctl_wr,
		.ram_ready, .ioctl_wait,
		.pifrom_wraddress, .pifrom_wrdata, .pifrom_wren,
		.ram_addr, .ram_data, .ram_wr,
		.romcopy_start, .romcopy_size, .cart_loaded
	);

	pll_reconfig u_pll_reconfig (
		.clk_1x, .RESET, .system_pal, .cfg_waitrequest,
		.cfg_write, .cfg_addr, .cfg_data
	);

	aspect_ratio u_aspect_ratio (
		.clk_1x, .RESET, .system_pal, .crop, .blanks_off, .direct_fb,
		.aspect_mode, .video_arx, .video_ary
	);

	snac_port_mux u_snac_port_mux (
		.clk_1x, .RESET, .snac_en, .pad_index, .snac_out, .user_in,
		.user_out, .snac_in
	);

endmodule

`default_nettype wire

//--- design/pll_reconfig.sv
`timescale 1ns/10ps
`default_nettype none

module pll_reconfig (
	input  wire                  clk_1x,
	input  wire                  RESET,
	input  wire                  system_pal,
	input  wire                  cfg_waitrequest,
	output logic                 cfg_write,
	output glue_pkg::cfg_addr_t  cfg_addr,
	output glue_pkg::word_t      cfg_data
);
	import glue_pkg::*;

	logic       pal_d;
	logic       pal_d2;
	logic       restart;
	logic       issue;
	cfg_state_t state;
	cfg_addr_t  next_addr;
	word_t      next_data;

	assign restart = pal_d ^ pal_d2;

	// Write decode for the current state
	always_comb begin
		issue     = 1'b0;
		next_addr = CFG_REG_MODE;
		next_data = '0;
		if (!cfg_waitrequest && !restart) begin
			case (state)
				CFG_MODE: issue = 1'b1;
				CFG_FRAC: begin
					issue     = 1'b1;
					next_addr = CFG_REG_FRAC;
					next_data = pal_d2 ? FRAC_PAL : FRAC_NTSC;
				end
				CFG_START: begin
					issue     = 1'b1;
					next_addr = CFG_REG_START;
				end
				default: issue = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			// Preload so reset alone starts no sequence
			pal_d     <= system_pal;
			pal_d2    <= system_pal;
			cfg_write <= 1'b0;
			state     <= CFG_IDLE;
		end else begin
			pal_d     <= system_pal;
			pal_d2    <= pal_d;
			cfg_write <= issue;
			if (restart)
				state <= CFG_MODE;
			else if (!cfg_waitrequest) begin
				case (state)
					CFG_MODE:  state <= CFG_GAP1;
					CFG_GAP1:  state <= CFG_FRAC;
					CFG_FRAC:  state <= CFG_GAP2;
					CFG_GAP2:  state <= CFG_START;
					CFG_START: state <= CFG_GAP3;
					default:   state <= CFG_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (issue) begin
			cfg_addr <= next_addr;
			cfg_data <= next_data;
		end
	end

endmodule

`default_nettype wire

//--- design/rom_download.sv
`timescale 1ns/10ps
`default_nettype none

module rom_download (
	input  wire                        clk_1x,
	input  wire                        RESET,
	input  wire                        ioctl_download,
	input  wire glue_pkg::dl_index_t   ioctl_index,
	input  wire glue_pkg::ioctl_addr_t ioctl_addr,
	input  wire glue_pkg::ioctl_data_t ioctl_dout,
	input  wire                        ioctl_wr,
	input  wire                        ram_ready,
	output logic                       ioctl_wait,
	output glue_pkg::pifrom_addr_t     pifrom_wraddress,
	output glue_pkg::word_t            pifrom_wrdata,
	output logic                       pifrom_wren,
	output glue_pkg::ioctl_addr_t      ram_addr,
	output glue_pkg::word_t            ram_data,
	output logic                       ram_wr,
	output logic                       romcopy_start,
	output glue_pkg::ioctl_addr_t      romcopy_size,
	output logic                       cart_loaded
);
	import glue_pkg::*;

	logic        pifrom_dl;
	logic        n64_dl;
	logic        gb_dl;
	logic        download_d;
	logic        dl_end;
	ioctl_addr_t dl_end_addr;
	logic        wr_lo;
	logic        wr_hi;

	// Address bit 1 tells the first half-word from the second
	assign wr_lo = ioctl_wr & ~ioctl_addr[1];
	assign wr_hi = ioctl_wr & ioctl_addr[1];

	//==========================================================================
	// Download flags, strobes and back-pressure
	//==========================================================================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pifrom_dl     <= 1'b0;
			n64_dl        <= 1'b0;
			gb_dl         <= 1'b0;
			download_d    <= 1'b0;
			dl_end        <= 1'b0;
			romcopy_start <= 1'b0;
			pifrom_wren   <= 1'b0;
			ram_wr        <= 1'b0;
			cart_loaded   <= 1'b0;
			ioctl_wait    <= 1'b0;
		end else begin
			pifrom_dl  <= ioctl_download & (ioctl_index[5:0] == DL_PIFROM);
			n64_dl     <= ioctl_download & (ioctl_index[5:0] == DL_CART_N64);
			gb_dl      <= ioctl_download & (ioctl_index[5:0] == DL_CART_GB);
			download_d <= ioctl_download;

			// Falling edge of an N64 download, start copy one stage later
			dl_end        <= ~ioctl_download & download_d & (ioctl_index[5:0] == DL_CART_N64);
			romcopy_start <= dl_end;

			pifrom_wren <= pifrom_dl & wr_hi;
			ram_wr      <= gb_dl & wr_hi;

			if (n64_dl)
				cart_loaded <= 1'b1;

			// Hold the host until the RAM takes the word
			if (!gb_dl)
				ioctl_wait <= 1'b0;
			else if (wr_hi)
				ioctl_wait <= 1'b1;
			else if (ram_ready)
				ioctl_wait <= 1'b0;
		end
	end

	//==========================================================================
	// Word assembly
	//==========================================================================

	always_ff @(posedge clk_1x) begin
		dl_end_addr <= ioctl_addr;
		if (dl_end)
			romcopy_size <= dl_end_addr;

		// PIF ROM bytes are swapped within each half-word
		if (pifrom_dl && wr_lo) begin
			pifrom_wrdata[31:16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
			pifrom_wraddress     <= {ioctl_index[6], ioctl_addr[10:2]};
		end
		if (pifrom_dl && wr_hi)
			pifrom_wrdata[15:0] <= {ioctl_dout[7:0], ioctl_dout[15:8]};

		// GB image, low half first
		if (gb_dl && wr_lo) begin
			ram_data[15:0] <= ioctl_dout;
			ram_addr       <= ioctl_addr + CARTGB_START;
		end
		if (gb_dl && wr_hi)
			ram_data[31:16] <= ioctl_dout;
	end

endmodule

`default_nettype wire

//--- design/snac_port_mux.sv
`timescale 1ns/10ps
`default_nettype none

module snac_port_mux (
	input  wire                       clk_1x,
	input  wire                       RESET,
	input  wire                       snac_en,
	input  wire glue_pkg::pad_index_t pad_index,
	input  wire                       snac_out,
	input  wire [6:0]                 user_in,
	output logic [6:0]                user_out,
	output logic                      snac_in
);
	import glue_pkg::*;

	logic [2:0] pin;

	// Pads 1..4 map to D-, D+, RX-, RX+
	assign pin = SNAC_PIN[pad_index];

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			user_out <= '1;
			snac_in  <= 1'b1;
		end else if (snac_en) begin
			user_out[pin] <= snac_out;
			snac_in       <= user_in[pin];
			// Unused pins released (open drain)
			user_out[2] <= 1'b1;
			user_out[3] <= 1'b1;
			user_out[6] <= 1'b1;
		end else begin
			user_out <= '1;
		end
	end

endmodule

`default_nettype wire

//--- project.f
design/glue_pkg.sv
design/rom_download.sv
design/pll_reconfig.sv
design/aspect_ratio.sv
design/snac_port_mux.sv
design/glue_top.sv
sim/glue_chk.sv
sim/tb_glue.sv

//--- sim/glue_chk.sv
`timescale 1ns/10ps
`default_nettype none

module glue_chk (
	input wire       clk_1x,
	input wire       RESET,
	input wire       pifrom_wren,
	input wire       ram_wr,
	input wire       romcopy_start,
	input wire       ioctl_wait,
	input wire       cfg_write,
	input wire       cfg_waitrequest,
	input wire       cart_loaded,
	input wire [6:0] user_out
);

	// Write strobes are single-cycle pulses
	a_pif_pulse: assert property (@(posedge clk_1x) disable iff (!RESET)
		pifrom_wren |=> !pifrom_wren)
		else $error("pifrom_wren high in two consecutive cycles");

	a_ram_pulse: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr |=> !ram_wr)
		else $error("ram_wr high in two consecutive cycles");

	a_copy_pulse: assert property (@(posedge clk_1x) disable iff (!RESET)
		romcopy_start |=> !romcopy_start)
		else $error("romcopy_start high in two consecutive cycles");

	// Host is held while a RAM write is outstanding
	a_ram_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr |-> ioctl_wait)
		else $error("ram_wr without ioctl_wait");

	a_cfg_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
		cfg_write |-> $past(!cfg_waitrequest))
		else $error("cfg_write after a cycle with cfg_waitrequest high");

	// First cycle out of reset
	a_reset_idle: assert property (@(posedge clk_1x)
		$rose(RESET) |-> (!pifrom_wren && !ram_wr && !ioctl_wait && !romcopy_start
			&& !cart_loaded && !cfg_write && user_out == 7'h7f))
		else $error("outputs not inactive after reset");

endmodule

`default_nettype wire

//--- sim/tb_glue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_glue;

	localparam int N_PIF  = 64;
	localparam int N_GB   = 32;
	localparam int N_N64  = 16;
	localparam int N_PLL  = 8;
	localparam int N_AR   = 24;
	localparam int N_SNAC = 64;

	// Phase lengths in cycles for the run limit
	localparam int LEN_RESET   = 8;
	localparam int LEN_PIF     = N_PIF * 5 + 8;
	localparam int LEN_GB      = N_GB * 14 + 8;
	localparam int LEN_N64     = N_N64 * 2 + 12;
	localparam int LEN_PLL     = (N_PLL + 1) * 24;
	localparam int LEN_AR      = 2 * N_AR * 5 + 4;
	localparam int LEN_SNAC    = N_SNAC + 4;
	localparam int CYCLE_LIMIT = 2 * (LEN_RESET + LEN_PIF + LEN_GB + LEN_N64 + LEN_PLL
		+ LEN_AR + LEN_SNAC);

	localparam logic [26:0] GB_OFFSET = 27'd8388608;
	localparam logic [31:0] PAL_FRAC  = 32'd4024384270;
	localparam logic [31:0] NTSC_FRAC = 32'd3274482981;
	localparam logic [31:0] REG_MODE  = 32'd0;
	localparam logic [31:0] REG_FRAC  = 32'd7;
	localparam logic [31:0] REG_START = 32'd2;

	logic        clk_1x;
	logic        RESET;
	logic        system_pal;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic        ram_ready = 1'b0;
	logic        cfg_waitrequest = 1'b0;
	logic [1:0]  crop;
	logic        blanks_off;
	logic        direct_fb;
	logic [1:0]  aspect_mode;
	logic        snac_en;
	logic [1:0]  pad_index;
	logic        snac_out;
	logic [6:0]  user_in;

	wire         ioctl_wait;
	wire  [9:0]  pifrom_wraddress;
	wire  [31:0] pifrom_wrdata;
	wire         pifrom_wren;
	wire  [26:0] ram_addr;
	wire  [31:0] ram_data;
	wire         ram_wr;
	wire         romcopy_start;
	wire  [26:0] romcopy_size;
	wire         cart_loaded;
	wire         cfg_write;
	wire  [5:0]  cfg_addr;
	wire  [31:0] cfg_data;
	wire  [12:0] video_arx;
	wire  [12:0] video_ary;
	wire  [6:0]  user_out;
	wire         snac_in;

	integer seed = 32'h6052;
	integer resp_seed = 32'h6052;
	int     cycles = 0;
	int     ram_delay = 0;
	int     pif_count = 0;
	int     ram_count = 0;
	int     copy_count = 0;
	int     cfg_count = 0;

	logic [31:0] pif_addr_q[$];
	logic [31:0] pif_data_q[$];
	logic [31:0] ram_addr_q[$];
	logic [31:0] ram_data_q[$];
	logic [31:0] cfg_addr_q[$];
	logic [31:0] cfg_data_q[$];

	// Reference state for the aspect and user-port models
	logic [12:0] ar_x = 13'd4;
	logic [12:0] ar_y = 13'd3;
	logic [6:0]  m_user = 7'h7f;
	logic        m_snac = 1'b1;

	glue_top DUT (.*);

	bind glue_top glue_chk u_chk (
		.clk_1x(clk_1x), .RESET(RESET), .pifrom_wren(pifrom_wren), .ram_wr(ram_wr),
		.romcopy_start(romcopy_start), .ioctl_wait(ioctl_wait), .cfg_write(cfg_write),
		.cfg_waitrequest(cfg_waitrequest), .cart_loaded(cart_loaded), .user_out(user_out)
	);

	initial clk_1x = 1'b0;
	always #10 clk_1x = ~clk_1x;

	//==========================================================================
	// Helpers
	//==========================================================================

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "run stopped");
		end
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_1x);
	endtask

	task automatic host_write(input logic [26:0] a, input logic [15:0] d);
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr   = 1'b1;
		@(negedge clk_1x);
	endtask

	// Scaler ratios per standard and crop
	function automatic logic [12:0] ar_table(input logic pal, input logic [1:0] c,
		input logic want_y);
		case ({pal, c, want_y})
			4'b1000: return 13'd512;
			4'b1001: return 13'd387;
			4'b1010: return 13'd1024;
			4'b1011: return 13'd731;
			4'b1100: return 13'd2048;
			4'b1101: return 13'd1419;
			4'b0000: return 13'd512;
			4'b0001: return 13'd381;
			4'b0010: return 13'd1280;
			4'b0011: return 13'd889;
			4'b0100: return 13'd2560;
			4'b0101: return 13'd1714;
			default: return 13'd0;
		endcase
	endfunction

	function automatic logic [2:0] snac_pin(input logic [1:0] pad);
		case (pad)
			2'd0:    return 3'd1;
			2'd1:    return 3'd0;
			2'd2:    return 3'd5;
			default: return 3'd4;
		endcase
	endfunction

	//==========================================================================
	// Responders, monitor and run limit
	//==========================================================================

	always @(posedge clk_1x) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

	// RAM answers 1 to 8 cycles after each write
	always @(negedge clk_1x) begin : ram_responder
		logic [31:0] r;
		ram_ready = 1'b0;
		if (ram_delay > 0) begin
			check(32'(ioctl_wait), 32'd1, "ioctl_wait while a RAM write is outstanding");
			ram_delay = ram_delay - 1;
			if (ram_delay == 0)
				ram_ready = 1'b1;
		end else if (ram_wr) begin
			r = $random(resp_seed);
			ram_delay = 1 + int'(r[2:0]);
		end else begin
			check(32'(ioctl_wait), 32'd0, "ioctl_wait with no RAM write outstanding");
		end
	end

	always @(negedge clk_1x) begin : pll_responder
		logic [31:0] r;
		r = $random(resp_seed);
		cfg_waitrequest = (r[1:0] == 2'b00);
	end

	always @(negedge clk_1x) begin : output_monitor
		if (RESET) begin
			if (pifrom_wren) begin
				pif_count = pif_count + 1;
				if (pif_addr_q.size() == 0)
					fail_run("pifrom_wren pulsed with no PIF ROM word pending");
				else begin
					check(32'(pifrom_wraddress), pif_addr_q.pop_front(), "PIF ROM address");
					check(pifrom_wrdata, pif_data_q.pop_front(), "PIF ROM data");
				end
			end
			if (ram_wr) begin
				ram_count = ram_count + 1;
				if (ram_addr_q.size() == 0)
					fail_run("ram_wr pulsed with no cartridge RAM word pending");
				else begin
					check(32'(ram_addr), ram_addr_q.pop_front(), "cartridge RAM address");
					check(ram_data, ram_data_q.pop_front(), "cartridge RAM data");
				end
			end
			if (cfg_write) begin
				cfg_count = cfg_count + 1;
				if (cfg_addr_q.size() == 0)
					fail_run("cfg_write pulsed with no PLL write pending");
				else begin
					check(32'(cfg_addr), cfg_addr_q.pop_front(), "PLL register address");
					check(cfg_data, cfg_data_q.pop_front(), "PLL register data");
				end
			end
			if (romcopy_start)
				copy_count = copy_count + 1;
		end
	end

	//==========================================================================
	// Phases
	//==========================================================================

	task automatic pif_download();
		logic [31:0] r;
		logic [26:0] a;
		logic [15:0] d0;
		logic [15:0] d1;
		logic        bank;
		int          i;
		r = rand32();
		bank = r[0];
		ioctl_index = {1'b0, bank, 6'd0};
		ioctl_download = 1'b1;
		wait_cycles(2);
		for (i = 0; i < N_PIF; i++) begin
			r = rand32();
			a = {r[26:2], 2'b00};
			r = rand32();
			d0 = r[15:0];
			d1 = r[31:16];
			// First half-word on top with bytes swapped in each half
			pif_addr_q.push_back(32'({bank, a[10:2]}));
			pif_data_q.push_back({d0[7:0], d0[15:8], d1[7:0], d1[15:8]});
			host_write(a, d0);
			host_write(a | 27'd2, d1);
			ioctl_wr = 1'b0;
			r = rand32();
			wait_cycles(int'(r[1:0]));
		end
		wait_cycles(3);
		ioctl_download = 1'b0;
		wait_cycles(2);
		check(32'(pif_count), 32'(N_PIF), "PIF ROM write count");
	endtask

	task automatic gb_download();
		logic [31:0] r;
		logic [26:0] a;
		logic [26:0] ga;
		logic [15:0] d0;
		logic [15:0] d1;
		int          i;
		ioctl_index = 8'd2;
		ioctl_download = 1'b1;
		wait_cycles(2);
		for (i = 0; i < N_GB; i++) begin
			while (ioctl_wait)
				@(negedge clk_1x);
			r = rand32();
			a = {r[26:2], 2'b00};
			ga = a + GB_OFFSET;
			r = rand32();
			d0 = r[15:0];
			d1 = r[31:16];
			ram_addr_q.push_back(32'(ga));
			ram_data_q.push_back({d1, d0});
			host_write(a, d0);
			host_write(a | 27'd2, d1);
			ioctl_wr = 1'b0;
		end
		while (ioctl_wait)
			@(negedge clk_1x);
		ioctl_download = 1'b0;
		wait_cycles(2);
		check(32'(ram_count), 32'(N_GB), "cartridge RAM write count");
	endtask

	task automatic n64_download();
		logic [31:0] r;
		logic [26:0] final_addr;
		int          i;
		check(32'(cart_loaded), 32'd0, "cart_loaded before N64 download");
		ioctl_index = 8'd1;
		ioctl_download = 1'b1;
		wait_cycles(2);
		check(32'(cart_loaded), 32'd1, "cart_loaded after N64 download start");
		for (i = 0; i < N_N64; i++) begin
			r = rand32();
			host_write(r[26:0], r[31:16]);
			ioctl_wr = 1'b0;
			@(negedge clk_1x);
		end
		r = rand32();
		final_addr = r[26:0];
		ioctl_addr = final_addr;
		ioctl_download = 1'b0;
		wait_cycles(2);
		check(32'(romcopy_start), 32'd1, "romcopy_start after N64 download end");
		check(32'(romcopy_size), 32'(final_addr), "romcopy_size");
		wait_cycles(4);
		check(32'(copy_count), 32'd1, "romcopy_start pulse count");
		check(32'(cart_loaded), 32'd1, "cart_loaded held after download");
	endtask

	task automatic pll_toggle();
		int target;
		system_pal = ~system_pal;
		cfg_addr_q.push_back(REG_MODE);
		cfg_data_q.push_back(32'd0);
		cfg_addr_q.push_back(REG_FRAC);
		cfg_data_q.push_back(system_pal ? PAL_FRAC : NTSC_FRAC);
		cfg_addr_q.push_back(REG_START);
		cfg_data_q.push_back(32'd0);
		target = cfg_count + 3;
		while (cfg_count < target)
			@(negedge clk_1x);
		wait_cycles(6);
	endtask

	task automatic aspect_phase();
		logic [31:0] r;
		logic [12:0] exp_x;
		logic [12:0] exp_y;
		int          i;
		for (i = 0; i < N_AR; i++) begin
			r = rand32();
			crop        = r[1:0];
			blanks_off  = (r[4:2] == 3'd0);
			direct_fb   = (r[7:5] == 3'd0);
			aspect_mode = r[9:8];
			if (blanks_off || direct_fb) begin
				ar_x = 13'd4;
				ar_y = 13'd3;
			end else if (crop != 2'd3) begin
				ar_x = ar_table(system_pal, crop, 1'b0);
				ar_y = ar_table(system_pal, crop, 1'b1);
			end
			// Nonzero modes are scaler presets
			exp_x = (aspect_mode == 2'd0) ? ar_x : {11'd0, aspect_mode - 2'd1};
			exp_y = (aspect_mode == 2'd0) ? ar_y : 13'd0;
			repeat (1 + int'(r[11:10])) begin
				@(negedge clk_1x);
				check(32'(video_arx), 32'(exp_x), "video_arx");
				check(32'(video_ary), 32'(exp_y), "video_ary");
			end
		end
		crop = 2'd3;
		blanks_off = 1'b0;
		direct_fb = 1'b0;
		aspect_mode = 2'd0;
		wait_cycles(1);
	endtask

	task automatic snac_phase();
		logic [31:0] r;
		logic [2:0]  pin;
		int          i;
		for (i = 0; i < N_SNAC; i++) begin
			r = rand32();
			snac_en   = (r[2:0] != 3'd0);
			pad_index = r[4:3];
			snac_out  = r[5];
			user_in   = r[12:6];
			pin = snac_pin(pad_index);
			if (snac_en) begin
				m_user[pin] = snac_out;
				m_snac = user_in[pin];
				m_user[2] = 1'b1;
				m_user[3] = 1'b1;
				m_user[6] = 1'b1;
			end else begin
				m_user = 7'h7f;
			end
			@(negedge clk_1x);
			check(32'(user_out), 32'(m_user), "user_out");
			check(32'(snac_in), 32'(m_snac), "snac_in");
		end
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================

	initial begin
		RESET          = 1'b0;
		system_pal     = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = 27'd0;
		ioctl_dout     = 16'd0;
		ioctl_wr       = 1'b0;
		crop           = 2'd3;
		blanks_off     = 1'b0;
		direct_fb      = 1'b0;
		aspect_mode    = 2'd0;
		snac_en        = 1'b0;
		pad_index      = 2'd0;
		snac_out       = 1'b0;
		user_in        = 7'd0;
		repeat (4) @(posedge clk_1x);
		@(negedge clk_1x);
		RESET = 1'b1;
		wait_cycles(2);

		pif_download();
		gb_download();
		n64_download();
		repeat (N_PLL) pll_toggle();
		aspect_phase();
		pll_toggle();
		aspect_phase();
		snac_phase();

		wait_cycles(4);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
